// ==== source/video_pkg.sv ====
// Video config package holding widths, port map, reset values and the shared bundles
`default_nettype none

package video_pkg;

    typedef logic [7:0] byte_t;      // Port value
    typedef logic [8:0] offs_t;      // Scroll offset or raster line
    typedef logic [8:0] coord_t;     // Layer fetch coordinate
    typedef logic [7:0] hcount_t;    // Pixel clock within a line
    typedef logic [8:0] vcount_t;    // Line within a frame
    typedef logic [4:0] port_idx_t;  // Port number from paddr[6:2]

    localparam int H_TOTAL = 224;
    localparam int V_TOTAL = 320;

    localparam port_idx_t P_ZBORDER   = 5'd0;
    localparam port_idx_t P_BORDER    = 5'd1;
    localparam port_idx_t P_ZVPAGE    = 5'd2;
    localparam port_idx_t P_VPAGE     = 5'd3;
    localparam port_idx_t P_VCONF     = 5'd4;
    localparam port_idx_t P_GX_OFFSL  = 5'd5;
    localparam port_idx_t P_GX_OFFSH  = 5'd6;
    localparam port_idx_t P_GY_OFFSL  = 5'd7;
    localparam port_idx_t P_GY_OFFSH  = 5'd8;
    localparam port_idx_t P_T0X_OFFSL = 5'd9;
    localparam port_idx_t P_T0X_OFFSH = 5'd10;
    localparam port_idx_t P_T0Y_OFFSL = 5'd11;
    localparam port_idx_t P_T0Y_OFFSH = 5'd12;
    localparam port_idx_t P_T1X_OFFSL = 5'd13;
    localparam port_idx_t P_T1X_OFFSH = 5'd14;
    localparam port_idx_t P_T1Y_OFFSL = 5'd15;
    localparam port_idx_t P_T1Y_OFFSH = 5'd16;
    localparam port_idx_t P_TSCONF    = 5'd17;
    localparam port_idx_t P_PALSEL    = 5'd18;
    localparam port_idx_t P_TMPAGE    = 5'd19;
    localparam port_idx_t P_T0GPAGE   = 5'd20;
    localparam port_idx_t P_T1GPAGE   = 5'd21;
    localparam port_idx_t P_SGPAGE    = 5'd22;
    localparam port_idx_t P_HINT_BEG  = 5'd23;
    localparam port_idx_t P_VINT_BEGL = 5'd24;
    localparam port_idx_t P_VINT_BEGH = 5'd25;
    localparam int        N_PORTS     = 26;

    localparam byte_t RST_VPAGE    = 8'h05;
    localparam byte_t RST_PALSEL   = 8'h0F;
    localparam byte_t RST_HINT_BEG = 8'd2;

    // Highest port first, so bit n of the struct is the strobe of port n
    typedef struct packed {
        logic vint_begh;
        logic vint_begl;
        logic hint_beg;
        logic sgpage;
        logic t1gpage;
        logic t0gpage;
        logic tmpage;
        logic palsel;
        logic tsconf;
        logic t1y_offsh;
        logic t1y_offsl;
        logic t1x_offsh;
        logic t1x_offsl;
        logic t0y_offsh;
        logic t0y_offsl;
        logic t0x_offsh;
        logic t0x_offsl;
        logic gy_offsh;
        logic gy_offsl;
        logic gx_offsh;
        logic gx_offsl;
        logic vconf;
        logic vpage;
        logic zvpage;
        logic border;
        logic zborder;
    } port_wr_t;

    typedef struct packed {
        byte_t border;
        byte_t vpage;
        byte_t vconf;
        byte_t tsconf;
        byte_t palsel;
        offs_t gx_offs;
        offs_t gy_offs;
        offs_t t0x_offs;
        offs_t t0y_offs;
        offs_t t1x_offs;
        offs_t t1y_offs;
        byte_t hint_beg;
        offs_t vint_beg;
        byte_t tmpage;
        byte_t t0gpage;
        byte_t t1gpage;
        byte_t sgpage;
    } video_params_t;

    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
    } beam_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } coord_pair_t;

    typedef struct packed {
        coord_pair_t gfx;
        coord_pair_t t0;
        coord_pair_t t1;
        coord_pair_t spr;  // Unscrolled, equals the beam
    } layer_coords_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

endpackage

`default_nettype wire

// ==== source/video_apb_decoder.sv ====
// APB slave of the video ports, giving write strobes, read-back data and unmapped errors
`timescale 1ns/1ps
`default_nettype none

module video_apb_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [7:0]                paddr,
    input  video_pkg::byte_t          pwdata,
    input  video_pkg::video_params_t  params,
    output video_pkg::byte_t          prdata,
    output logic                      pready,
    output logic                      pslverr,
    output video_pkg::port_wr_t       port_wr,
    output video_pkg::byte_t          wdata
);

    video_pkg::port_idx_t           idx;
    logic                           mapped;
    logic                           access;
    video_pkg::byte_t               rd_val;
    logic [video_pkg::N_PORTS-1:0]  strobe;
    video_pkg::apb_state_t          phase;
    video_pkg::apb_state_t          phase_q;

    assign idx    = paddr[6:2];                              // Byte lanes ignored
    assign mapped = !paddr[7] && (idx < video_pkg::N_PORTS);
    assign access = psel && penable;

    assign pready  = access;                                 // No wait states
    assign pslverr = access && !mapped;
    assign wdata   = pwdata;
    assign prdata  = mapped ? rd_val : '0;

    always_comb
    begin
        strobe = '0;
        if (access && pwrite && mapped)
            strobe[idx] = 1'b1;
    end

    assign port_wr = video_pkg::port_wr_t'(strobe);

    always_comb
    begin
        case (idx)
            video_pkg::P_ZBORDER,
            video_pkg::P_BORDER:    rd_val = params.border;
            video_pkg::P_ZVPAGE,
            video_pkg::P_VPAGE:     rd_val = params.vpage;
            video_pkg::P_VCONF:     rd_val = params.vconf;
            video_pkg::P_GX_OFFSL:  rd_val = params.gx_offs[7:0];
            video_pkg::P_GX_OFFSH:  rd_val = {7'b0, params.gx_offs[8]};
            video_pkg::P_GY_OFFSL:  rd_val = params.gy_offs[7:0];
            video_pkg::P_GY_OFFSH:  rd_val = {7'b0, params.gy_offs[8]};
            video_pkg::P_T0X_OFFSL: rd_val = params.t0x_offs[7:0];
            video_pkg::P_T0X_OFFSH: rd_val = {7'b0, params.t0x_offs[8]};
            video_pkg::P_T0Y_OFFSL: rd_val = params.t0y_offs[7:0];
            video_pkg::P_T0Y_OFFSH: rd_val = {7'b0, params.t0y_offs[8]};
            video_pkg::P_T1X_OFFSL: rd_val = params.t1x_offs[7:0];
            video_pkg::P_T1X_OFFSH: rd_val = {7'b0, params.t1x_offs[8]};
            video_pkg::P_T1Y_OFFSL: rd_val = params.t1y_offs[7:0];
            video_pkg::P_T1Y_OFFSH: rd_val = {7'b0, params.t1y_offs[8]};
            video_pkg::P_TSCONF:    rd_val = params.tsconf;
            video_pkg::P_PALSEL:    rd_val = params.palsel;
            video_pkg::P_TMPAGE:    rd_val = params.tmpage;
            video_pkg::P_T0GPAGE:   rd_val = params.t0gpage;
            video_pkg::P_T1GPAGE:   rd_val = params.t1gpage;
            video_pkg::P_SGPAGE:    rd_val = params.sgpage;
            video_pkg::P_HINT_BEG:  rd_val = params.hint_beg;
            video_pkg::P_VINT_BEGL: rd_val = params.vint_beg[7:0];
            video_pkg::P_VINT_BEGH: rd_val = {7'b0, params.vint_beg[8]};
            default:                rd_val = '0;
        endcase
    end

    always_comb
    begin
        if (!psel)
            phase = video_pkg::IDLE;
        else if (!penable)
            phase = video_pkg::SETUP;
        else
            phase = video_pkg::ACCESS;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            phase_q <= video_pkg::IDLE;
        else
            phase_q <= phase;
    end

    // penable only ever comes right after a setup cycle
    a_access_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == video_pkg::ACCESS) |-> (phase_q == video_pkg::SETUP));

    // psel stays up and penable rises in the cycle after setup
    a_setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == video_pkg::SETUP) |=> (phase == video_pkg::ACCESS));

endmodule

`default_nettype wire

// ==== source/video_ports.sv ====
// Video parameter latch, loaded from the decoder's per-port write strobes
`timescale 1ns/1ps
`default_nettype none

module video_ports (
    input  logic                      clk,
    input  logic                      rst_n,
    input  video_pkg::port_wr_t       port_wr,
    input  video_pkg::byte_t          wdata,
    output video_pkg::video_params_t  params
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            params.border   <= '0;
            params.vpage    <= video_pkg::RST_VPAGE;
            params.vconf    <= '0;
            params.tsconf   <= '0;
            params.palsel   <= video_pkg::RST_PALSEL;
            params.gx_offs  <= '0;
            params.gy_offs  <= '0;
            params.t0x_offs <= '0;
            params.t0y_offs <= '0;
            params.t1x_offs <= '0;
            params.t1y_offs <= '0;
            params.hint_beg <= video_pkg::RST_HINT_BEG;
            params.vint_beg <= '0;
            params.tmpage   <= '0;
            params.t0gpage  <= '0;
            params.t1gpage  <= '0;
            params.sgpage   <= '0;
        end
        else
        begin
            // Legacy border and page formats
            if (port_wr.zborder)
                params.border <= {5'b11110, wdata[2:0]};
            if (port_wr.zvpage)
                params.vpage <= {6'b000001, wdata[3], 1'b1};

            if (port_wr.border)
                params.border <= wdata;
            if (port_wr.vpage)
                params.vpage <= wdata;
            if (port_wr.vconf)
                params.vconf <= wdata;
            if (port_wr.tsconf)
                params.tsconf <= wdata;
            if (port_wr.palsel)
                params.palsel <= wdata;

            if (port_wr.gx_offsl)
                params.gx_offs[7:0] <= wdata;
            if (port_wr.gx_offsh)
                params.gx_offs[8] <= wdata[0];  // Only bit 0 is kept
            if (port_wr.gy_offsl)
                params.gy_offs[7:0] <= wdata;
            if (port_wr.gy_offsh)
                params.gy_offs[8] <= wdata[0];
            if (port_wr.t0x_offsl)
                params.t0x_offs[7:0] <= wdata;
            if (port_wr.t0x_offsh)
                params.t0x_offs[8] <= wdata[0];
            if (port_wr.t0y_offsl)
                params.t0y_offs[7:0] <= wdata;
            if (port_wr.t0y_offsh)
                params.t0y_offs[8] <= wdata[0];
            if (port_wr.t1x_offsl)
                params.t1x_offs[7:0] <= wdata;
            if (port_wr.t1x_offsh)
                params.t1x_offs[8] <= wdata[0];
            if (port_wr.t1y_offsl)
                params.t1y_offs[7:0] <= wdata;
            if (port_wr.t1y_offsh)
                params.t1y_offs[8] <= wdata[0];

            if (port_wr.tmpage)
                params.tmpage <= wdata;
            if (port_wr.t0gpage)
                params.t0gpage <= wdata;
            if (port_wr.t1gpage)
                params.t1gpage <= wdata;
            if (port_wr.sgpage)
                params.sgpage <= wdata;

            if (port_wr.hint_beg)
                params.hint_beg <= wdata;
            if (port_wr.vint_begl)
                params.vint_beg[7:0] <= wdata;
            if (port_wr.vint_begh)
                params.vint_beg[8] <= wdata[0];
        end
    end

    // The decoder never addresses two ports at once
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(port_wr));

endmodule

`default_nettype wire

// ==== source/video_raster_timer.sv ====
// Raster timer with line and frame counters and the frame interrupt pulse
`timescale 1ns/1ps
`default_nettype none

module video_raster_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  video_pkg::byte_t  hint_beg,
    input  video_pkg::offs_t  vint_beg,
    output video_pkg::beam_t  beam,
    output logic              frame_int
);

    video_pkg::hcount_t  hcount;
    video_pkg::vcount_t  vcount;
    logic                line_end;
    logic                frame_end;
    logic                at_int_pos;
    logic                int_hit;

    assign line_end   = hcount == video_pkg::hcount_t'(video_pkg::H_TOTAL - 1);
    assign frame_end  = vcount == video_pkg::vcount_t'(video_pkg::V_TOTAL - 1);

    // Never true when vint_beg lies past the last line
    assign at_int_pos = (hcount == hint_beg) && (vcount == vint_beg);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hcount <= '0;
            vcount <= '0;
        end
        else if (line_end)
        begin
            hcount <= '0;
            if (frame_end)
                vcount <= '0;
            else
                vcount <= vcount + 1'b1;
        end
        else
        begin
            hcount <= hcount + 1'b1;
        end
    end

    // Compare flop then output flop, so the pulse lines up with the beam
    // one position past the interrupt point at the scroll unit's output
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            int_hit   <= 1'b0;
            frame_int <= 1'b0;
        end
        else
        begin
            int_hit   <= at_int_pos;
            frame_int <= int_hit;
        end
    end

    assign beam = '{hcount: hcount, vcount: vcount};

    a_hcount_range: assert property (@(posedge clk) disable iff (!rst_n)
        hcount < video_pkg::H_TOTAL);

    a_vcount_range: assert property (@(posedge clk) disable iff (!rst_n)
        vcount < video_pkg::V_TOTAL);

    // One interrupt per frame, never a two-cycle pulse
    a_int_single: assert property (@(posedge clk) disable iff (!rst_n)
        frame_int |=> !frame_int);

endmodule

`default_nettype wire

// ==== source/video_scroll.sv ====
// Scroll unit adding layer offsets to the beam position, registered with the beam
`timescale 1ns/1ps
`default_nettype none

module video_scroll (
    input  logic                      clk,
    input  logic                      rst_n,
    input  video_pkg::beam_t          beam_in,
    input  video_pkg::video_params_t  params,
    output video_pkg::beam_t          beam,
    output video_pkg::layer_coords_t  coords
);

    video_pkg::layer_coords_t  coords_next;

    // 9-bit sums, so coordinates wrap modulo 512
    function automatic video_pkg::coord_pair_t scroll_pair(
        input video_pkg::beam_t  pos,
        input video_pkg::offs_t  x_offs,
        input video_pkg::offs_t  y_offs
    );
        video_pkg::coord_pair_t  pair;
        pair.x = video_pkg::coord_t'(pos.hcount) + x_offs;
        pair.y = pos.vcount + y_offs;
        return pair;
    endfunction

    always_comb
    begin
        coords_next.gfx   = scroll_pair(beam_in, params.gx_offs, params.gy_offs);
        coords_next.t0    = scroll_pair(beam_in, params.t0x_offs, params.t0y_offs);
        coords_next.t1    = scroll_pair(beam_in, params.t1x_offs, params.t1y_offs);
        coords_next.spr.x = video_pkg::coord_t'(beam_in.hcount);  // Sprites unscrolled
        coords_next.spr.y = beam_in.vcount;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            beam   <= '0;
            coords <= '0;
        end
        else
        begin
            beam   <= beam_in;
            coords <= coords_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/video_subsystem.sv ====
// Video configuration top with APB decoder, port latch, raster timer and scroll unit
`timescale 1ns/1ps
`default_nettype none

module video_subsystem (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [7:0]                paddr,
    input  video_pkg::byte_t          pwdata,
    output video_pkg::byte_t          prdata,
    output logic                      pready,
    output logic                      pslverr,
    output video_pkg::video_params_t  vparams,
    output video_pkg::beam_t          beam,
    output video_pkg::layer_coords_t  coords,
    output logic                      frame_int
);

    video_pkg::port_wr_t  port_wr;
    video_pkg::byte_t     wdata;
    video_pkg::beam_t     timer_beam;  // Timer count, one cycle ahead of beam

    video_apb_decoder u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .params  (vparams),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .port_wr (port_wr),
        .wdata   (wdata)
    );

    video_ports u_ports (
        .clk     (clk),
        .rst_n   (rst_n),
        .port_wr (port_wr),
        .wdata   (wdata),
        .params  (vparams)
    );

    video_raster_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .hint_beg  (vparams.hint_beg),
        .vint_beg  (vparams.vint_beg),
        .beam      (timer_beam),
        .frame_int (frame_int)
    );

    video_scroll u_scroll (
        .clk     (clk),
        .rst_n   (rst_n),
        .beam_in (timer_beam),
        .params  (vparams),
        .beam    (beam),
        .coords  (coords)
    );

endmodule

`default_nettype wire

// ==== test/tb_video_model.svh ====
// Reference model of the video ports, their address map and the layer coordinate rule
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

video_pkg::video_params_t  model;  // Shadow of the port latch

function automatic video_pkg::port_idx_t port_of(input logic [7:0] addr);
    return addr[6:2];  // Byte lanes ignored
endfunction

function automatic logic is_mapped(input logic [7:0] addr);
    return int'(port_of(addr)) < video_pkg::N_PORTS;
endfunction

task automatic model_reset();
    model          = '0;
    model.vpage    = video_pkg::RST_VPAGE;
    model.palsel   = video_pkg::RST_PALSEL;
    model.hint_beg = video_pkg::RST_HINT_BEG;
endtask

task automatic model_write(input logic [7:0] addr, input video_pkg::byte_t data);
    case (port_of(addr))
        video_pkg::P_ZBORDER:   model.border = {5'b11110, data[2:0]};
        video_pkg::P_BORDER:    model.border = data;
        video_pkg::P_ZVPAGE:    model.vpage = {6'b000001, data[3], 1'b1};
        video_pkg::P_VPAGE:     model.vpage = data;
        video_pkg::P_VCONF:     model.vconf = data;
        video_pkg::P_GX_OFFSL:  model.gx_offs[7:0] = data;
        video_pkg::P_GX_OFFSH:  model.gx_offs[8] = data[0];
        video_pkg::P_GY_OFFSL:  model.gy_offs[7:0] = data;
        video_pkg::P_GY_OFFSH:  model.gy_offs[8] = data[0];
        video_pkg::P_T0X_OFFSL: model.t0x_offs[7:0] = data;
        video_pkg::P_T0X_OFFSH: model.t0x_offs[8] = data[0];
        video_pkg::P_T0Y_OFFSL: model.t0y_offs[7:0] = data;
        video_pkg::P_T0Y_OFFSH: model.t0y_offs[8] = data[0];
        video_pkg::P_T1X_OFFSL: model.t1x_offs[7:0] = data;
        video_pkg::P_T1X_OFFSH: model.t1x_offs[8] = data[0];
        video_pkg::P_T1Y_OFFSL: model.t1y_offs[7:0] = data;
        video_pkg::P_T1Y_OFFSH: model.t1y_offs[8] = data[0];
        video_pkg::P_TSCONF:    model.tsconf = data;
        video_pkg::P_PALSEL:    model.palsel = data;
        video_pkg::P_TMPAGE:    model.tmpage = data;
        video_pkg::P_T0GPAGE:   model.t0gpage = data;
        video_pkg::P_T1GPAGE:   model.t1gpage = data;
        video_pkg::P_SGPAGE:    model.sgpage = data;
        video_pkg::P_HINT_BEG:  model.hint_beg = data;
        video_pkg::P_VINT_BEGL: model.vint_beg[7:0] = data;
        video_pkg::P_VINT_BEGH: model.vint_beg[8] = data[0];
        default:                model = model;  // Unmapped, nothing stored
    endcase
endtask

function automatic video_pkg::byte_t model_read(input logic [7:0] addr);
    case (port_of(addr))
        video_pkg::P_ZBORDER,
        video_pkg::P_BORDER:    return model.border;
        video_pkg::P_ZVPAGE,
        video_pkg::P_VPAGE:     return model.vpage;
        video_pkg::P_VCONF:     return model.vconf;
        video_pkg::P_GX_OFFSL:  return model.gx_offs[7:0];
        video_pkg::P_GX_OFFSH:  return {7'b0, model.gx_offs[8]};
        video_pkg::P_GY_OFFSL:  return model.gy_offs[7:0];
        video_pkg::P_GY_OFFSH:  return {7'b0, model.gy_offs[8]};
        video_pkg::P_T0X_OFFSL: return model.t0x_offs[7:0];
        video_pkg::P_T0X_OFFSH: return {7'b0, model.t0x_offs[8]};
        video_pkg::P_T0Y_OFFSL: return model.t0y_offs[7:0];
        video_pkg::P_T0Y_OFFSH: return {7'b0, model.t0y_offs[8]};
        video_pkg::P_T1X_OFFSL: return model.t1x_offs[7:0];
        video_pkg::P_T1X_OFFSH: return {7'b0, model.t1x_offs[8]};
        video_pkg::P_T1Y_OFFSL: return model.t1y_offs[7:0];
        video_pkg::P_T1Y_OFFSH: return {7'b0, model.t1y_offs[8]};
        video_pkg::P_TSCONF:    return model.tsconf;
        video_pkg::P_PALSEL:    return model.palsel;
        video_pkg::P_TMPAGE:    return model.tmpage;
        video_pkg::P_T0GPAGE:   return model.t0gpage;
        video_pkg::P_T1GPAGE:   return model.t1gpage;
        video_pkg::P_SGPAGE:    return model.sgpage;
        video_pkg::P_HINT_BEG:  return model.hint_beg;
        video_pkg::P_VINT_BEGL: return model.vint_beg[7:0];
        video_pkg::P_VINT_BEGH: return {7'b0, model.vint_beg[8]};
        default:                return '0;
    endcase
endfunction

function automatic video_pkg::coord_t scrolled(input int pos, input video_pkg::offs_t offs);
    return video_pkg::coord_t'((pos + int'(offs)) % 512);
endfunction

function automatic video_pkg::layer_coords_t model_coords(
    input video_pkg::beam_t          b,
    input video_pkg::video_params_t  p
);
    video_pkg::layer_coords_t  c;
    c.gfx.x = scrolled(int'(b.hcount), p.gx_offs);
    c.gfx.y = scrolled(int'(b.vcount), p.gy_offs);
    c.t0.x  = scrolled(int'(b.hcount), p.t0x_offs);
    c.t0.y  = scrolled(int'(b.vcount), p.t0y_offs);
    c.t1.x  = scrolled(int'(b.hcount), p.t1x_offs);
    c.t1.y  = scrolled(int'(b.vcount), p.t1y_offs);
    c.spr.x = scrolled(int'(b.hcount), '0);
    c.spr.y = scrolled(int'(b.vcount), '0);
    return c;
endfunction

// Next raster position, wrapping at the end of a line and of a frame
function automatic video_pkg::beam_t beam_advance(input video_pkg::beam_t b);
    video_pkg::beam_t  n;
    n = b;
    if (int'(b.hcount) == video_pkg::H_TOTAL - 1)
    begin
        n.hcount = '0;
        n.vcount = (int'(b.vcount) == video_pkg::V_TOTAL - 1) ? '0 : b.vcount + 1'b1;
    end
    else
    begin
        n.hcount = b.hcount + 1'b1;
    end
    return n;
endfunction

`endif

// ==== test/tb_video_subsystem.sv ====
// Testbench of the video configuration block with random APB traffic and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_video_subsystem;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int N_RANDOM     = 400;
    localparam int N_INT_TRIALS = 2;
    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;

    logic                      clk;
    logic                      rst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [7:0]                paddr;
    video_pkg::byte_t          pwdata;
    video_pkg::byte_t          prdata;
    logic                      pready;
    logic                      pslverr;
    video_pkg::video_params_t  vparams;
    video_pkg::beam_t          beam;
    video_pkg::layer_coords_t  coords;
    logic                      frame_int;

    video_pkg::video_params_t  snap;        // Parameters seen by the scroll unit
    video_pkg::beam_t          prev_beam;
    logic                      beam_track;
    logic                      pend_valid;  // Write taken at the coming edge
    logic [7:0]                pend_addr;
    video_pkg::byte_t          pend_data;

    `include "tb_video_model.svh"

    video_subsystem u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .vparams   (vparams),
        .beam      (beam),
        .coords    (coords),
        .frame_int (frame_int)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_byte(input string what, input video_pkg::byte_t got,
                                input video_pkg::byte_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_params(input string what, input video_pkg::video_params_t got,
                                  input video_pkg::video_params_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_coords(input string what, input video_pkg::layer_coords_t got,
                                  input video_pkg::layer_coords_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_beam(input string what, input video_pkg::beam_t got,
                                input video_pkg::beam_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is h=%0d v=%0d, expected h=%0d v=%0d", $time, what,
                     got.hcount, got.vcount, exp.hcount, exp.vcount);
            stop_run();
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // One clock, then check every output that is stable at the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (pend_valid)
        begin
            model_write(pend_addr, pend_data);
            pend_valid = 1'b0;
        end
        compare_params("vparams", vparams, model);
        compare_coords("coords", coords, model_coords(beam, snap));
        if (beam_track)
            compare_beam("beam", beam, beam_advance(prev_beam));
        snap       = model;
        prev_beam  = beam;
        beam_track = 1'b1;
    endtask

    function automatic logic [7:0] port_addr(input int port, input logic [1:0] lane);
        return {1'b0, port[4:0], lane};
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input video_pkg::byte_t data);
        video_pkg::byte_t  exp_rd;
        logic              exp_err;
        exp_rd  = model_read(addr);
        exp_err = !is_mapped(addr);
        psel    = 1'b1;         // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;         // Access phase
        #(CLK_PERIOD / 4);
        compare_flag("pready", pready, 1'b1);
        compare_flag("pslverr", pslverr, exp_err);
        if (!wr)
            compare_byte("prdata", prdata, exp_rd);
        if (wr && !exp_err)
        begin
            pend_valid = 1'b1;
            pend_addr  = addr;
            pend_data  = data;
        end
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_frame_int(input int limit, output int waited);
        waited = 0;
        while (frame_int !== 1'b1)
        begin
            if (waited >= limit)
            begin
                $display("Timed out waiting for frame_int after %0d cycles", waited);
                stop_run();
            end
            else
            begin
                next_cycle();
                waited++;
            end
        end
    endtask

    initial
    begin
        logic [1:0]         lane;
        video_pkg::byte_t   hint;
        video_pkg::offs_t   vint;
        video_pkg::beam_t   int_pos;
        int                 waited;

        $timeformat(-9, 0, " ns", 0);
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pend_valid = 1'b0;
        pend_addr  = '0;
        pend_data  = '0;
        beam_track = 1'b0;
        prev_beam  = '0;
        model_reset();
        snap = model;
        void'($urandom(32'h5df2baa4));

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        next_cycle();
        compare_flag("frame_int after reset", frame_int, 1'b0);
        compare_beam("beam after reset", beam, '0);  // Raster starts at the origin

        for (int p = 0; p < video_pkg::N_PORTS; p++)
            apb_access(1'b0, port_addr(p, 2'b00), '0);  // Reset values read back

        for (int i = 0; i < N_RANDOM; i++)
        begin
            lane = 2'($urandom_range(3, 0));
            apb_access(1'($urandom_range(1, 0)), port_addr($urandom_range(31, 0), lane),
                       video_pkg::byte_t'($urandom));
            repeat ($urandom_range(2, 0)) next_cycle();
        end

        for (int t = 0; t < N_INT_TRIALS; t++)
        begin
            hint = video_pkg::byte_t'($urandom_range(video_pkg::H_TOTAL - 1, 0));
            vint = video_pkg::offs_t'($urandom_range(video_pkg::V_TOTAL - 1, 0));
            apb_access(1'b1, port_addr(video_pkg::P_HINT_BEG, 2'b00), hint);
            apb_access(1'b1, port_addr(video_pkg::P_VINT_BEGL, 2'b00), vint[7:0]);
            apb_access(1'b1, port_addr(video_pkg::P_VINT_BEGH, 2'b00), {7'b0, vint[8]});
            repeat (2) next_cycle();  // Flush pulses of the old position
            int_pos = '{hcount: hint, vcount: vint};

            wait_frame_int(FRAME_CYCLES + 16, waited);
            compare_beam("beam at frame_int", beam, beam_advance(int_pos));
            next_cycle();
            compare_flag("frame_int one cycle later", frame_int, 1'b0);
            wait_frame_int(FRAME_CYCLES + 16, waited);
            if (waited + 1 != FRAME_CYCLES)
            begin
                $display("ERR %0t: interrupt period is %0d cycles, expected %0d",
                         $time, waited + 1, FRAME_CYCLES);
                stop_run();
            end
            compare_beam("beam at next frame_int", beam, beam_advance(int_pos));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== video_subsystem.f ====
+incdir+test
source/video_pkg.sv
source/video_apb_decoder.sv
source/video_ports.sv
source/video_raster_timer.sv
source/video_scroll.sv
source/video_subsystem.sv
test/tb_video_subsystem.sv

// ==== Bender.yml ====
package:
  name: video_subsystem

sources:
  # RTL in compile order
  - source/video_pkg.sv
  - source/video_apb_decoder.sv
  - source/video_ports.sv
  - source/video_raster_timer.sv
  - source/video_scroll.sv
  - source/video_subsystem.sv

  # Testbench with its model header
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_video_subsystem.sv
